//--- Bender.yml
package:
  name: valu

sources:
  # RTL in compile order
  - hdl/valu_pkg.sv
  - hdl/valu_pipe_stage.sv
  - hdl/valu_operand_stage.sv
  - hdl/valu_lane_array.sv
  - hdl/valu_mask_tail.sv
  - hdl/valu_top.sv

  # Testbench
  - target: test
    files:
      - testbench/valu_assert.sv
      - testbench/valu_tb.sv

//--- hdl/valu_lane_array.sv
`timescale 1ns/100ps

module valu_lane_array
    import valu_pkg::*;
(
    input  valu_operands_t    operands,
    output valu_lane_result_t result
);

    // One full result vector per element width
    logic [3:0][vlen-1:0] width_res;

    // --------------------------------------------------
    // Single element ALU
    // --------------------------------------------------
    // Operands arrive zero-extended from the element width
    function automatic logic [elen-1:0] elem_alu(
        input valu_opcode_t    op,
        input logic [elen-1:0] a,
        input logic [elen-1:0] b,
        input vsew_t           sew
    );
        logic [6:0]             ew;
        logic [elen-1:0]        mask;
        logic [elen-1:0]        a_u;
        logic [elen-1:0]        b_u;
        logic signed [elen-1:0] a_s;
        logic signed [elen-1:0] b_s;
        logic [5:0]             sh;
        logic [elen-1:0]        r;

        ew   = 7'd8 << sew;
        mask = {elen{1'b1}} >> (7'd64 - ew);
        a_u  = a & mask;
        b_u  = b & mask;
        a_s  = a_u | (a_u[ew-1] ? ~mask : '0);
        b_s  = b_u | (b_u[ew-1] ? ~mask : '0);
        // Shift amount wraps at the element width
        sh   = b_u[5:0] & 6'(ew - 7'd1);

        case (op)
            vadd:    r = a_u + b_u;
            vsub:    r = a_u - b_u;
            vrsub:   r = b_u - a_u;
            vand:    r = a_u & b_u;
            vor:     r = a_u | b_u;
            vxor:    r = a_u ^ b_u;
            vminu:   r = (a_u < b_u) ? a_u : b_u;
            vmin:    r = (a_s < b_s) ? a_u : b_u;
            vmaxu:   r = (a_u > b_u) ? a_u : b_u;
            vmax:    r = (a_s > b_s) ? a_u : b_u;
            vmseq:   r = elen'(a_u == b_u);
            vmsne:   r = elen'(a_u != b_u);
            vmsltu:  r = elen'(a_u < b_u);
            vmslt:   r = elen'(a_s < b_s);
            vmsgtu:  r = elen'(a_u > b_u);
            vmsgt:   r = elen'(a_s > b_s);
            vsll:    r = a_u << sh;
            vsrl:    r = a_u >> sh;
            vsra:    r = a_s >>> sh;
            vmv:     r = b_u;
            default: r = '0;
        endcase
        return r;
    endfunction

    // --------------------------------------------------
    // Element slicing per width
    // --------------------------------------------------
    for (genvar w = 0; w < 4; w++) begin : g_width
        localparam int ew = 8 << w;
        localparam int ne = vlen / ew;

        for (genvar i = 0; i < ne; i++) begin : g_elem
            logic [elen-1:0] full;

            assign full = elem_alu(operands.opcode,
                                   elen'(operands.op_a.bits[i*ew +: ew]),
                                   elen'(operands.op_b.bits[i*ew +: ew]),
                                   vsew_t'(w));
            assign width_res[w][i*ew +: ew] = full[ew-1:0];
        end
    end

    always_comb begin
        result.cfg      = operands.cfg;
        result.res.bits = width_res[operands.cfg.vsew];
        result.vs3      = operands.vs3;
        result.vmask    = operands.vmask;
    end

endmodule

//--- hdl/valu_mask_tail.sv
`timescale 1ns/100ps

module valu_mask_tail
    import valu_pkg::*;
(
    input  valu_lane_result_t lane_result,
    output vreg_t             vd
);

    localparam int nbytes   = vlen / 8;
    localparam int idx_bits = $clog2(max_elems);

    // --------------------------------------------------
    // Byte-wise policy select
    // --------------------------------------------------
    // Each byte looks up the element it belongs to at the current width
    always_comb begin
        logic [idx_bits-1:0] idx;
        logic                tail;
        logic                off;
        vcfg_t               cfg;

        cfg = lane_result.cfg;
        vd  = lane_result.res;

        for (int j = 0; j < nbytes; j++) begin
            idx  = idx_bits'(j) >> cfg.vsew;
            tail = {1'b0, idx} >= cfg.vl;
            off  = !cfg.vm && !lane_result.vmask[idx];

            if (tail) begin
                vd.bits[j*8 +: 8] = cfg.vta ? 8'hff : lane_result.vs3.bits[j*8 +: 8];
            end else if (off) begin
                vd.bits[j*8 +: 8] = cfg.vma ? 8'hff : lane_result.vs3.bits[j*8 +: 8];
            end
        end
    end

endmodule

//--- hdl/valu_operand_stage.sv
`timescale 1ns/100ps

module valu_operand_stage
    import valu_pkg::*;
(
    input  valu_instr_t    instr,
    output valu_operands_t operands
);

    logic [elen-1:0] imm_ext;

    // Copy the low element of a scalar into every element slot
    function automatic vreg_t splat(
        input logic [elen-1:0] value,
        input vsew_t           sew
    );
        vreg_t v;
        case (sew)
            sew8:    v.bits = {(vlen/8){value[7:0]}};
            sew16:   v.bits = {(vlen/16){value[15:0]}};
            sew32:   v.bits = {(vlen/32){value[31:0]}};
            default: v.bits = {(vlen/64){value[63:0]}};
        endcase
        return v;
    endfunction

    // Sign-extended to the widest element, so any low slice is correct too
    assign imm_ext = {{(elen-5){instr.imm[4]}}, instr.imm};

    always_comb begin
        operands.opcode = instr.opcode;
        operands.cfg    = instr.cfg;
        operands.op_a   = instr.vs1;
        operands.vs3    = instr.vs3;
        operands.vmask  = instr.vmask;

        case (instr.mode)
            vs_op:   operands.op_b = splat(instr.rs1, instr.cfg.vsew);
            vi_op:   operands.op_b = splat(imm_ext, instr.cfg.vsew);
            default: operands.op_b = instr.vs2;
        endcase
    end

endmodule

//--- hdl/valu_pipe_stage.sv
`timescale 1ns/100ps

module valu_pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Free slot, or the current entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

//--- hdl/valu_pkg.sv
package valu_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int vlen      = 128;
    localparam int elen      = 64;
    localparam int max_elems = vlen / 8;
    localparam int vl_width  = $clog2(max_elems) + 1;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [1:0] {
        sew8  = 2'd0,
        sew16 = 2'd1,
        sew32 = 2'd2,
        sew64 = 2'd3
    } vsew_t;

    typedef enum logic [1:0] {
        vv_op = 2'd0,
        vs_op = 2'd1,
        vi_op = 2'd2
    } valu_mode_t;

    typedef enum logic [4:0] {
        vadd, vsub, vrsub,
        vand, vor, vxor,
        vminu, vmin, vmaxu, vmax,
        vmseq, vmsne,
        vmsltu, vmslt, vmsgtu, vmsgt,
        vsll, vsrl, vsra,
        vmv
    } valu_opcode_t;

    // --------------------------------------------------
    // Payloads
    // --------------------------------------------------
    typedef struct packed {
        logic [vlen-1:0] bits;
    } vreg_t;

    typedef struct packed {
        vsew_t               vsew;
        logic                vta;
        logic                vma;
        logic [vl_width-1:0] vl;
        logic                vm;
    } vcfg_t;

    typedef struct packed {
        valu_mode_t           mode;
        valu_opcode_t         opcode;
        vcfg_t                cfg;
        vreg_t                vs1;
        vreg_t                vs2;
        vreg_t                vs3;
        logic [elen-1:0]      rs1;
        logic [4:0]           imm;
        logic [max_elems-1:0] vmask;
    } valu_instr_t;

    typedef struct packed {
        valu_opcode_t         opcode;
        vcfg_t                cfg;
        vreg_t                op_a;
        vreg_t                op_b;
        vreg_t                vs3;
        logic [max_elems-1:0] vmask;
    } valu_operands_t;

    // Raw ALU result plus what the output side needs for the policy
    typedef struct packed {
        vcfg_t                cfg;
        vreg_t                res;
        vreg_t                vs3;
        logic [max_elems-1:0] vmask;
    } valu_lane_result_t;

endpackage

//--- hdl/valu_top.sv
`timescale 1ns/100ps

module valu_top
    import valu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    output logic        in_ready,
    input  valu_instr_t in_instr,

    output logic        out_valid,
    input  logic        out_ready,
    output vreg_t       out_data
);

    valu_operands_t    operands_d;
    valu_operands_t    s1_data;
    logic              s1_valid;
    valu_lane_result_t lane_d;
    valu_lane_result_t s2_data;
    logic              s2_valid;
    logic              s2_ready;
    vreg_t             vd;
    logic              s3_ready;

    // --------------------------------------------------
    // Operand build and stage 1
    // --------------------------------------------------
    valu_operand_stage i_operand_stage (
        .instr    (in_instr),
        .operands (operands_d)
    );

    valu_pipe_stage #(.payload_t(valu_operands_t)) i_stage1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (operands_d),
        .out_valid (s1_valid),
        .out_ready (s2_ready),
        .out_data  (s1_data)
    );

    // --------------------------------------------------
    // Lanes and stage 2
    // --------------------------------------------------
    valu_lane_array i_lane_array (
        .operands (s1_data),
        .result   (lane_d)
    );

    valu_pipe_stage #(.payload_t(valu_lane_result_t)) i_stage2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .in_ready  (s2_ready),
        .in_data   (lane_d),
        .out_valid (s2_valid),
        .out_ready (s3_ready),
        .out_data  (s2_data)
    );

    // Mask/tail policy, then the output register
    valu_mask_tail i_mask_tail (
        .lane_result (s2_data),
        .vd          (vd)
    );

    valu_pipe_stage #(.payload_t(vreg_t)) i_stage3 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s2_valid),
        .in_ready  (s3_ready),
        .in_data   (vd),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

//--- testbench/valu_assert.sv
`timescale 1ns/100ps

module valu_assert
    import valu_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input vreg_t out_data
);

    // --------------------------------------------------
    // Reset and output handshake
    // --------------------------------------------------
    assert property (@(posedge clk) rst |-> !out_valid)
    else $error("out_valid high during reset");

    // Stalled result must not change
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("out_valid or out_data changed while stalled");

    // Empty output stage lets every stage accept
    assert property (@(posedge clk) disable iff (rst)
        !out_valid |-> in_ready)
    else $error("in_ready low with the output stage empty");

    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_data))
    else $error("out_data has unknown bits while out_valid is high");

endmodule

//--- testbench/valu_tb.sv
`timescale 1ns/100ps

module valu_tb
    import valu_pkg::*;
();

    localparam int wait_limit   = 200;
    localparam int ready_high   = 0;
    localparam int ready_random = 1;
    localparam int ready_low    = 2;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    valu_instr_t in_instr;
    logic        out_valid;
    logic        out_ready;
    vreg_t       out_data;

    int          seed       = 60;
    int          ready_seed = 60;
    int          ready_mode = ready_high;
    string       cur_test   = "reset";

    // Expected results in acceptance order, a ring indexed by the pointers
    vreg_t       exp_mem [1024];
    string       exp_name [1024];
    logic [9:0]  wr_ptr = '0;
    logic [9:0]  rd_ptr;
    vreg_t       exp_head;

    valu_top i_valu_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind valu_top valu_assert i_valu_assert (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // out_ready pattern is picked at the edge and driven just after it
    initial begin
        int mode_now;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            mode_now = ready_mode;
            #1;
            if (mode_now == ready_random) begin
                out_ready = 1'($random(ready_seed));
            end else begin
                out_ready = (mode_now == ready_high);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (out_valid && out_ready) begin
            rd_ptr <= rd_ptr + 10'd1;
        end
    end

    assign exp_head = exp_mem[rd_ptr];

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    // --------------------------------------------------
    // Output checks
    // --------------------------------------------------
    assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (rd_ptr != wr_ptr))
    else stop_on_error("Output transfer with no instruction outstanding");

    assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (out_data == exp_head))
    else begin
        $display("ERR %s: expected %h, actual %h",
                 exp_name[$sampled(rd_ptr)], $sampled(exp_head), $sampled(out_data));
        stop_on_error("Result mismatch at the output");
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [63:0] ref_elem(input valu_opcode_t op, input logic [63:0] a,
                                             input logic [63:0] b, input int ew);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        int                 amt;
        // Element moved to the top bits so that the signed order holds
        sa  = a << (64 - ew);
        sb  = b << (64 - ew);
        amt = b % ew;
        case (op)
            vadd:    return a + b;
            vsub:    return a - b;
            vrsub:   return b - a;
            vand:    return a & b;
            vor:     return a | b;
            vxor:    return a ^ b;
            vminu:   return (a < b) ? a : b;
            vmin:    return (sa < sb) ? a : b;
            vmaxu:   return (a > b) ? a : b;
            vmax:    return (sa > sb) ? a : b;
            vmseq:   return 64'(a == b);
            vmsne:   return 64'(a != b);
            vmsltu:  return 64'(a < b);
            vmslt:   return 64'(sa < sb);
            vmsgtu:  return 64'(a > b);
            vmsgt:   return 64'(sa > sb);
            vsll:    return a << amt;
            vsrl:    return a >> amt;
            vsra:    return (sa >>> amt) >> (64 - ew);
            vmv:     return b;
            default: return '0;
        endcase
    endfunction

    function automatic vreg_t ref_model(input valu_instr_t instr);
        vreg_t       vd;
        int          ew;
        int          ne;
        logic [63:0] wmask;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] old;
        logic [63:0] r;
        ew      = 8 << instr.cfg.vsew;
        ne      = 128 / ew;
        wmask   = (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
        vd.bits = '0;
        for (int i = 0; i < ne; i++) begin
            a   = 64'(instr.vs1.bits >> (i * ew)) & wmask;
            old = 64'(instr.vs3.bits >> (i * ew)) & wmask;
            case (instr.mode)
                vs_op:   b = instr.rs1 & wmask;
                vi_op:   b = 64'($signed(instr.imm)) & wmask;
                default: b = 64'(instr.vs2.bits >> (i * ew)) & wmask;
            endcase
            r = ref_elem(instr.opcode, a, b, ew) & wmask;
            if (i >= instr.cfg.vl) begin
                r = instr.cfg.vta ? wmask : old;
            end else if (!instr.cfg.vm && !instr.vmask[i]) begin
                r = instr.cfg.vma ? wmask : old;
            end
            vd.bits = vd.bits | (128'(r) << (i * ew));
        end
        return vd;
    endfunction

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    function automatic logic [127:0] rand128();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic valu_instr_t make_instr(input valu_mode_t mode, input valu_opcode_t op,
                                               input int sew);
        valu_instr_t instr;
        instr.mode      = mode;
        instr.opcode    = op;
        instr.cfg.vsew  = vsew_t'(sew);
        instr.cfg.vta   = 1'b0;
        instr.cfg.vma   = 1'b0;
        instr.cfg.vl    = vl_width'(max_elems >> sew);
        instr.cfg.vm    = 1'b1;
        instr.vs1.bits  = rand128();
        instr.vs2.bits  = rand128();
        instr.vs3.bits  = rand128();
        // Upper scalar bits must not leak into narrow elements
        instr.rs1       = {1'b1, 31'($random(seed)), 32'($random(seed))};
        instr.imm       = 5'($random(seed));
        instr.vmask     = 16'($random(seed));
        // Some equal elements for the compares
        if ($random(seed) % 2 == 0) begin
            instr.vs2.bits[63:0] = instr.vs1.bits[63:0];
        end
        return instr;
    endfunction

    // Called just after an edge; returns just after the accepting edge
    task automatic send(input valu_instr_t instr);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_instr = instr;
        #1;
        while (!in_ready) begin
            if (waited >= wait_limit) begin
                stop_on_error("Timeout waiting for in_ready");
            end else begin
                @(posedge clk);
                #2;
                waited++;
            end
        end
        exp_mem[wr_ptr]  = ref_model(instr);
        exp_name[wr_ptr] = cur_test;
        wr_ptr           = wr_ptr + 10'd1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (rd_ptr != wr_ptr) begin
            if (waited >= wait_limit) begin
                stop_on_error("Timeout waiting for the pipeline to drain");
            end else begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
    endtask

    task automatic run_ops(input string name, input int first, input int last,
                           input valu_mode_t mode, input int reps);
        valu_instr_t instr;
        cur_test = name;
        for (int sew = 0; sew < 4; sew++) begin
            for (int op = first; op <= last; op++) begin
                repeat (reps) begin
                    instr = make_instr(mode, valu_opcode_t'(op), sew);
                    send(instr);
                end
            end
        end
    endtask

    initial begin
        valu_instr_t instr;
        in_valid = 1'b0;
        in_instr = '0;
        rst      = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        run_ops("vv_arith", int'(vadd), int'(vxor), vv_op, 3);
        run_ops("vv_move", int'(vmv), int'(vmv), vv_op, 3);
        run_ops("vs_all", int'(vadd), int'(vmv), vs_op, 2);
        run_ops("vi_all", int'(vadd), int'(vmv), vi_op, 2);
        run_ops("sign_cmp", int'(vminu), int'(vmsgt), vv_op, 3);
        run_ops("shift_vv", int'(vsll), int'(vsra), vv_op, 3);
        run_ops("shift_vi", int'(vsll), int'(vsra), vi_op, 3);

        // All four vta/vma pairs, with vl = 0 once per width
        cur_test = "mask_tail";
        for (int pol = 0; pol < 4; pol++) begin
            for (int sew = 0; sew < 4; sew++) begin
                for (int k = 0; k < 3; k++) begin
                    instr = make_instr(vv_op, valu_opcode_t'(5'($unsigned($random(seed)) % 20)),
                                       sew);
                    instr.cfg.vta = pol[1];
                    instr.cfg.vma = pol[0];
                    instr.cfg.vm  = 1'b0;
                    instr.cfg.vl  = (k == 0) ? '0 :
                        vl_width'($unsigned($random(seed)) % ((max_elems >> sew) + 1));
                    send(instr);
                end
            end
        end

        cur_test   = "backpressure";
        ready_mode = ready_random;
        for (int n = 0; n < 200; n++) begin
            instr = make_instr(valu_mode_t'(2'($unsigned($random(seed)) % 3)),
                               valu_opcode_t'(5'($unsigned($random(seed)) % 20)),
                               int'($unsigned($random(seed)) % 4));
            {instr.cfg.vta, instr.cfg.vma, instr.cfg.vm} = 3'($random(seed));
            instr.cfg.vl = vl_width'($unsigned($random(seed)) % 17);
            send(instr);
        end
        ready_mode = ready_high;
        drain();

        // Three results held with out_ready low fill every stage
        cur_test   = "hold_low";
        ready_mode = ready_low;
        repeat (3) begin
            instr = make_instr(vv_op, vadd, 0);
            send(instr);
        end
        #1;
        assert (!in_ready) else stop_on_error("in_ready still high with all stages full");
        repeat (4) @(posedge clk);
        #2;
        assert (!in_ready) else stop_on_error("in_ready rose while out_ready was held low");
        ready_mode = ready_high;
        @(posedge clk);
        #1;
        drain();

        if (rd_ptr == wr_ptr) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error("Results still outstanding at the end of the run");
        end
    end

endmodule

//--- valu.f
hdl/valu_pkg.sv
hdl/valu_pipe_stage.sv
hdl/valu_operand_stage.sv
hdl/valu_lane_array.sv
hdl/valu_mask_tail.sv
hdl/valu_top.sv
testbench/valu_assert.sv
testbench/valu_tb.sv
